// ==== mmc3.f ====
src/mmc3_pkg.sv
src/mmc3_regs.sv
src/a12_filter.sv
src/scanline_irq.sv
src/prg_map.sv
src/chr_map.sv
src/mmc3.sv
test/clock_gen.sv
test/mmc3_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MMC3 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mmc3.f --top-module mmc3_tb -o mmc3_sim

./obj_dir/mmc3_sim 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== src/a12_filter.sv ====
/* PPU A12 rise filter */

`default_nettype none

module a12_filter #(
	parameter int A12_FILTER_LEN = mmc3_pkg::A12_FILTER_DEFAULT	// Low time in ce cycles
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  ce,
	input  wire  chr_a12,	// PPU A12
	output logic a12_clock	// One-clock tick to the IRQ counter
);

	logic [3:0] low_cnt;	// Remaining low time before a rise counts

	// A rise only counts once A12 has been low long enough
	assign a12_clock = ce && chr_a12 && (low_cnt == 4'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			low_cnt <= 4'd0;
		end else if (chr_a12) begin
			low_cnt <= 4'(A12_FILTER_LEN);	// Held while A12 is high
		end else if (ce && (low_cnt != 4'd0)) begin
			low_cnt <= low_cnt - 4'd1;
		end
	end

	// Sprite fetches toggle A12 several times per line
	// the reload keeps those rises from clocking twice

endmodule

`default_nettype wire

// ==== src/chr_map.sv ====
/* MMC3 CHR and nametable map */

`default_nettype none

module chr_map (
	input  mmc3_pkg::ppu_addr_t   chr_ain,
	input  wire                   chr_invert,	// Swap pattern table halves
	input  wire                   chr_ram,	// Board has CHR RAM
	input  wire                   mirroring,	// 1 = horizontal
	input  mmc3_pkg::chr_bank2_t  chr_bank_0,
	input  mmc3_pkg::chr_bank2_t  chr_bank_1,
	input  mmc3_pkg::chr_bank_t   chr_bank_2,
	input  mmc3_pkg::chr_bank_t   chr_bank_3,
	input  mmc3_pkg::chr_bank_t   chr_bank_4,
	input  mmc3_pkg::chr_bank_t   chr_bank_5,
	output mmc3_pkg::mem_addr_t   chr_aout,
	output logic                  chr_allow,
	output logic                  vram_a10,
	output logic                  vram_ce
);

	mmc3_pkg::chr_bank_t chr_sel;	// 1 KB page being fetched
	logic                half;	// Half after inversion

	assign half = chr_ain[12] ^ chr_invert;

	always_comb begin
		case ({half, chr_ain[11:10]})
			3'b000, 3'b001: chr_sel = {chr_bank_0, chr_ain[10]};	// 2 KB via R0
			3'b010, 3'b011: chr_sel = {chr_bank_1, chr_ain[10]};	// 2 KB via R1
			3'b100: chr_sel = chr_bank_2;
			3'b101: chr_sel = chr_bank_3;
			3'b110: chr_sel = chr_bank_4;
			default: chr_sel = chr_bank_5;
		endcase
	end

	assign chr_aout  = {mmc3_pkg::CHR_ROM_PREFIX, chr_sel, chr_ain[9:0]};
	assign chr_allow = chr_ram;	// Writes only reach RAM boards

	// Internal 2 KB VRAM for nametables
	assign vram_a10 = mirroring ? chr_ain[11] : chr_ain[10];
	assign vram_ce  = chr_ain[13];

endmodule

`default_nettype wire

// ==== src/mmc3.sv ====
/* MMC3 mapper top */

`default_nettype none

module mmc3 #(
	parameter int A12_FILTER_LEN = mmc3_pkg::A12_FILTER_DEFAULT
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   ce,	// CPU M2 strobe
	input  wire                   prg_write,
	input  mmc3_pkg::cpu_addr_t   prg_ain,
	input  mmc3_pkg::data_t       prg_din,
	input  mmc3_pkg::ppu_addr_t   chr_ain,
	input  wire                   chr_ram,	// Cart flag
	output mmc3_pkg::mem_addr_t   prg_aout,
	output logic                  prg_allow,
	output mmc3_pkg::mem_addr_t   chr_aout,
	output logic                  chr_allow,
	output logic                  vram_a10,
	output logic                  vram_ce,
	output logic                  irq
);

	mmc3_pkg::prg_bank_t  prg_bank_0, prg_bank_1;
	mmc3_pkg::chr_bank2_t chr_bank_0, chr_bank_1;
	mmc3_pkg::chr_bank_t  chr_bank_2, chr_bank_3, chr_bank_4, chr_bank_5;
	mmc3_pkg::irq_count_t irq_latch_data;
	logic                 prg_mode, chr_invert, mirroring;
	logic                 ram_enable, ram_protect;
	logic                 irq_latch_wr, irq_reload_wr, irq_disable_wr, irq_enable_wr;
	logic                 a12_clock;	// Filtered scanline tick

	mmc3_regs u_regs (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.prg_write(prg_write), .prg_ain(prg_ain), .prg_din(prg_din),
		.prg_bank_0(prg_bank_0), .prg_bank_1(prg_bank_1),
		.prg_mode(prg_mode), .chr_invert(chr_invert), .mirroring(mirroring),
		.ram_enable(ram_enable), .ram_protect(ram_protect),
		.chr_bank_0(chr_bank_0), .chr_bank_1(chr_bank_1),
		.chr_bank_2(chr_bank_2), .chr_bank_3(chr_bank_3),
		.chr_bank_4(chr_bank_4), .chr_bank_5(chr_bank_5),
		.irq_latch_wr(irq_latch_wr), .irq_reload_wr(irq_reload_wr),
		.irq_disable_wr(irq_disable_wr), .irq_enable_wr(irq_enable_wr),
		.irq_latch_data(irq_latch_data)
	);

	a12_filter #(.A12_FILTER_LEN(A12_FILTER_LEN)) u_a12_filter (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.chr_a12(chr_ain[12]), .a12_clock(a12_clock)
	);

	scanline_irq u_scanline_irq (
		.clk(clk), .rst_n(rst_n), .ce(ce), .a12_clock(a12_clock),
		.irq_latch_wr(irq_latch_wr), .irq_reload_wr(irq_reload_wr),
		.irq_disable_wr(irq_disable_wr), .irq_enable_wr(irq_enable_wr),
		.irq_latch_data(irq_latch_data), .irq(irq)
	);

	prg_map u_prg_map (
		.prg_ain(prg_ain), .prg_write(prg_write), .prg_mode(prg_mode),
		.ram_enable(ram_enable), .ram_protect(ram_protect),
		.prg_bank_0(prg_bank_0), .prg_bank_1(prg_bank_1),
		.prg_aout(prg_aout), .prg_allow(prg_allow)
	);

	chr_map u_chr_map (
		.chr_ain(chr_ain), .chr_invert(chr_invert), .chr_ram(chr_ram),
		.mirroring(mirroring),
		.chr_bank_0(chr_bank_0), .chr_bank_1(chr_bank_1),
		.chr_bank_2(chr_bank_2), .chr_bank_3(chr_bank_3),
		.chr_bank_4(chr_bank_4), .chr_bank_5(chr_bank_5),
		.chr_aout(chr_aout), .chr_allow(chr_allow),
		.vram_a10(vram_a10), .vram_ce(vram_ce)
	);

endmodule

`default_nettype wire

// ==== src/mmc3_pkg.sv ====
/* MMC3 shared types and constants */

`default_nettype none

package mmc3_pkg;

	// Bus widths
	typedef logic [15:0] cpu_addr_t;	// CPU address bus
	typedef logic [13:0] ppu_addr_t;	// PPU address bus
	typedef logic [7:0]  data_t;		// CPU data byte

	// Bank numbers
	typedef logic [5:0] prg_bank_t;		// 8 KB PRG page
	typedef logic [7:0] chr_bank_t;		// 1 KB CHR page
	typedef logic [6:0] chr_bank2_t;	// 2 KB CHR page, low bit dropped

	// Bank-select index, R0 to R7
	typedef logic [2:0] bank_sel_t;

	// Physical address toward ROM/RAM
	typedef logic [21:0] mem_addr_t;

	// Scanline counter and latch
	typedef logic [7:0] irq_count_t;

	// Fixed PRG windows
	localparam prg_bank_t PRG_LAST_BANK        = 6'b111111;	// $E000 window
	localparam prg_bank_t PRG_SECOND_LAST_BANK = 6'b111110;	// Swappable window when fixed

	// Memory map of the 22-bit output address
	localparam logic [8:0] PRG_RAM_PREFIX = 9'b111100000;	// 8 KB work RAM
	localparam logic [2:0] PRG_ROM_PREFIX = 3'b000;		// PRG ROM base
	localparam logic [3:0] CHR_ROM_PREFIX = 4'b1000;		// CHR ROM/RAM base

	// A12 low time needed before a rise counts, in ce cycles
	localparam int A12_FILTER_DEFAULT = 15;

endpackage

`default_nettype wire

// ==== src/mmc3_regs.sv ====
/* MMC3 CPU register file */

`default_nettype none

module mmc3_regs (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     ce,		// CPU M2 strobe
	input  wire                     prg_write,
	input  mmc3_pkg::cpu_addr_t     prg_ain,
	input  mmc3_pkg::data_t         prg_din,
	output mmc3_pkg::prg_bank_t     prg_bank_0,	// R6
	output mmc3_pkg::prg_bank_t     prg_bank_1,	// R7
	output logic                    prg_mode,
	output logic                    chr_invert,
	output logic                    mirroring,	// 1 = horizontal
	output logic                    ram_enable,
	output logic                    ram_protect,
	output mmc3_pkg::chr_bank2_t    chr_bank_0,	// R0
	output mmc3_pkg::chr_bank2_t    chr_bank_1,	// R1
	output mmc3_pkg::chr_bank_t     chr_bank_2,	// R2
	output mmc3_pkg::chr_bank_t     chr_bank_3,	// R3
	output mmc3_pkg::chr_bank_t     chr_bank_4,	// R4
	output mmc3_pkg::chr_bank_t     chr_bank_5,	// R5
	output logic                    irq_latch_wr,
	output logic                    irq_reload_wr,
	output logic                    irq_disable_wr,
	output logic                    irq_enable_wr,
	output mmc3_pkg::irq_count_t    irq_latch_data
);

	mmc3_pkg::bank_sel_t bank_sel;	// Target of next $8001 write
	logic                reg_wr;	// Write into $8000-$FFFF
	logic [2:0]          reg_addr;	// A14, A13, A0

	assign reg_wr   = ce && prg_write && prg_ain[15];
	assign reg_addr = {prg_ain[14:13], prg_ain[0]};

	// IRQ strobes go out in the write cycle itself
	assign irq_latch_wr   = reg_wr && (reg_addr == 3'b10_0);	// $C000
	assign irq_reload_wr  = reg_wr && (reg_addr == 3'b10_1);	// $C001
	assign irq_disable_wr = reg_wr && (reg_addr == 3'b11_0);	// $E000
	assign irq_enable_wr  = reg_wr && (reg_addr == 3'b11_1);	// $E001
	assign irq_latch_data = prg_din;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel    <= '0;
			prg_mode    <= 1'b0;
			chr_invert  <= 1'b0;
			mirroring   <= 1'b0;	// Vertical
			ram_enable  <= 1'b0;
			ram_protect <= 1'b0;
			prg_bank_0  <= '0;
			prg_bank_1  <= '0;
			chr_bank_0  <= '0;
			chr_bank_1  <= '0;
			chr_bank_2  <= '0;
			chr_bank_3  <= '0;
			chr_bank_4  <= '0;
			chr_bank_5  <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				3'b00_0: begin	// Bank select
					chr_invert <= prg_din[7];
					prg_mode   <= prg_din[6];
					bank_sel   <= prg_din[2:0];
				end
				3'b00_1: begin	// Bank data
					case (bank_sel)
						3'd0: chr_bank_0 <= prg_din[7:1];	// 2 KB pages
						3'd1: chr_bank_1 <= prg_din[7:1];
						3'd2: chr_bank_2 <= prg_din;
						3'd3: chr_bank_3 <= prg_din;
						3'd4: chr_bank_4 <= prg_din;
						3'd5: chr_bank_5 <= prg_din;
						3'd6: prg_bank_0 <= prg_din[5:0];
						default: prg_bank_1 <= prg_din[5:0];	// R7
					endcase
				end
				3'b01_0: mirroring <= prg_din[0];
				3'b01_1: begin	// PRG RAM control
					ram_enable  <= prg_din[7];
					ram_protect <= prg_din[6];
				end
				default: ;	// IRQ registers live in scanline_irq
			endcase
		end
	end

	// Only one IRQ register can be hit by a single write
	a_irq_wr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({irq_latch_wr, irq_reload_wr, irq_disable_wr, irq_enable_wr}));

endmodule

`default_nettype wire

// ==== src/prg_map.sv ====
/* MMC3 PRG address map */

`default_nettype none

module prg_map (
	input  mmc3_pkg::cpu_addr_t   prg_ain,
	input  wire                   prg_write,
	input  wire                   prg_mode,	// 1 swaps $8000 and $C000
	input  wire                   ram_enable,
	input  wire                   ram_protect,
	input  mmc3_pkg::prg_bank_t   prg_bank_0,	// R6
	input  mmc3_pkg::prg_bank_t   prg_bank_1,	// R7
	output mmc3_pkg::mem_addr_t   prg_aout,
	output logic                  prg_allow
);

	mmc3_pkg::prg_bank_t prg_sel;	// Bank of the addressed window
	logic                ram_hit;	// Work RAM access granted
	logic                rom_read;

	always_comb begin
		case (prg_ain[14:13])
			2'b00: begin	// $8000
				if (prg_mode)
					prg_sel = mmc3_pkg::PRG_SECOND_LAST_BANK;
				else
					prg_sel = prg_bank_0;
			end
			2'b01: prg_sel = prg_bank_1;	// $A000, both modes
			2'b10: begin	// $C000
				if (prg_mode)
					prg_sel = prg_bank_0;
				else
					prg_sel = mmc3_pkg::PRG_SECOND_LAST_BANK;
			end
			default: prg_sel = mmc3_pkg::PRG_LAST_BANK;	// $E000
		endcase
	end

	// $6000-$7FFF, writes blocked while protected
	assign ram_hit = (prg_ain[15:13] == 3'b011) && ram_enable
		&& !(prg_write && ram_protect);
	assign rom_read = prg_ain[15] && !prg_write;

	assign prg_aout = ram_hit ? {mmc3_pkg::PRG_RAM_PREFIX, prg_ain[12:0]}
		: {mmc3_pkg::PRG_ROM_PREFIX, prg_sel, prg_ain[12:0]};
	assign prg_allow = rom_read || ram_hit;

endmodule

`default_nettype wire

// ==== src/scanline_irq.sv ====
/* MMC3 scanline IRQ counter */

`default_nettype none

module scanline_irq (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     ce,
	input  wire                     a12_clock,	// Filtered A12 rise
	input  wire                     irq_latch_wr,
	input  wire                     irq_reload_wr,
	input  wire                     irq_disable_wr,
	input  wire                     irq_enable_wr,
	input  mmc3_pkg::irq_count_t    irq_latch_data,
	output logic                    irq
);

	mmc3_pkg::irq_count_t irq_latch;	// Reload value from $C000
	mmc3_pkg::irq_count_t irq_count;	// Scanline down-counter
	mmc3_pkg::irq_count_t next_count;
	logic                 irq_reload;	// Reload pending from $C001
	logic                 irq_enable;

	// Normal behavior: fires whenever the new value is zero
	assign next_count = (irq_count == '0 || irq_reload) ? irq_latch
		: irq_count - 8'd1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_latch  <= '0;
			irq_count  <= '0;
			irq_reload <= 1'b0;
			irq_enable <= 1'b0;
			irq        <= 1'b0;
		end else begin
			if (ce && a12_clock) begin
				irq_count  <= next_count;
				irq_reload <= 1'b0;
				if (next_count == '0 && irq_enable)
					irq <= 1'b1;
			end
			// CPU writes win over a counter tick in the same cycle
			if (irq_latch_wr)
				irq_latch <= irq_latch_data;
			if (irq_reload_wr)
				irq_reload <= 1'b1;
			if (irq_enable_wr)
				irq_enable <= 1'b1;
			if (irq_disable_wr) begin	// Also acknowledges
				irq_enable <= 1'b0;
				irq        <= 1'b0;
			end
		end
	end

	// An IRQ can only be raised by a tick seen while enabled
	a_irq_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq) |-> $past(irq_enable));

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
/* Testbench clock and reset */

`default_nettype none

module clock_gen #(
	parameter int PERIOD       = 40,	// Clock period in time units
	parameter int RESET_CYCLES = 8	// Cycles with rst_n held low
) (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;	// Released on a rising edge
	end

endmodule

`default_nettype wire

// ==== test/mmc3_tb.sv ====
/* MMC3 random-stimulus testbench */

`default_nettype none

module mmc3_tb;

	localparam int CLK_PERIOD      = 40;
	localparam int A12_FILTER_LEN  = mmc3_pkg::A12_FILTER_DEFAULT;
	localparam int A12_GAP         = A12_FILTER_LEN + 5;	// Low time between A12 pulses
	localparam int ACCESSES        = 6;	// Bus accesses per round
	localparam int PRG_ROUNDS      = 24;
	localparam int CHR_ROUNDS      = 24;
	localparam int RAM_ROUNDS      = 16;
	localparam int MIRROR_ROUNDS   = 12;
	localparam int NUM_OPS         = (PRG_ROUNDS + CHR_ROUNDS) * (2 + ACCESSES)
		+ (RAM_ROUNDS + MIRROR_ROUNDS) * (1 + ACCESSES) + 40;
	localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 1000;

	logic                 clk;
	logic                 rst_n;
	logic                 ce;
	logic                 prg_write;
	mmc3_pkg::cpu_addr_t  prg_ain;
	mmc3_pkg::data_t      prg_din;
	mmc3_pkg::ppu_addr_t  chr_ain;
	logic                 chr_ram;
	mmc3_pkg::mem_addr_t  prg_aout;
	logic                 prg_allow;
	mmc3_pkg::mem_addr_t  chr_aout;
	logic                 chr_allow;
	logic                 vram_a10;
	logic                 vram_ce;
	logic                 irq;

	// Reference model state
	mmc3_pkg::data_t      m_r [0:7];	// R0-R7 as written
	mmc3_pkg::bank_sel_t  m_sel;
	logic                 m_mode, m_inv, m_mirror, m_ram_en, m_ram_prot;
	mmc3_pkg::irq_count_t m_latch, m_count;
	logic                 m_reload, m_irq_en, m_irq;
	logic [31:0]          lfsr;	// Random source
	string                test_name;

	clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock_gen (.clk(clk), .rst_n(rst_n));

	mmc3 #(.A12_FILTER_LEN(A12_FILTER_LEN)) u_mmc3 (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.prg_write(prg_write), .prg_ain(prg_ain), .prg_din(prg_din),
		.chr_ain(chr_ain), .chr_ram(chr_ram),
		.prg_aout(prg_aout), .prg_allow(prg_allow),
		.chr_aout(chr_aout), .chr_allow(chr_allow),
		.vram_a10(vram_a10), .vram_ce(vram_ce), .irq(irq)
	);

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Register address in a page with random mirror bits
	function automatic mmc3_pkg::cpu_addr_t pick_reg_addr(input logic [1:0] page,
		input logic odd);
		logic [31:0] r;
		r = rand_bits(12);
		return {1'b1, page, r[11:0], odd};
	endfunction

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_addr(input string what, input mmc3_pkg::mem_addr_t exp,
		input mmc3_pkg::mem_addr_t act);
		if (act !== exp) begin
			$display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string what, input mmc3_pkg::irq_count_t exp,
		input mmc3_pkg::irq_count_t act);
		if (act !== exp) begin
			$display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			stop_with_failure();
		end
	endtask

	function automatic void model_reset();
		for (int i = 0; i < 8; i++)
			m_r[i] = '0;
		m_sel = '0;
		{m_mode, m_inv, m_mirror, m_ram_en, m_ram_prot} = '0;	// Mirroring vertical
		m_latch = '0;
		m_count = '0;
		{m_reload, m_irq_en, m_irq} = '0;
	endfunction

	// Register writes as decoded by A14, A13 and A0
	function automatic void model_write(input mmc3_pkg::cpu_addr_t addr,
		input mmc3_pkg::data_t data);
		if (addr[15]) begin
			case ({addr[14:13], addr[0]})
				3'b000: begin
					m_inv  = data[7];
					m_mode = data[6];
					m_sel  = data[2:0];
				end
				3'b001: m_r[m_sel] = data;
				3'b010: m_mirror = data[0];
				3'b011: begin
					m_ram_en   = data[7];
					m_ram_prot = data[6];
				end
				3'b100: m_latch = data;
				3'b101: m_reload = 1'b1;
				3'b110: begin	// Disable and acknowledge
					m_irq_en = 1'b0;
					m_irq    = 1'b0;
				end
				default: m_irq_en = 1'b1;
			endcase
		end
	endfunction

	function automatic void model_a12_tick();
		if (m_count == '0 || m_reload)
			m_count = m_latch;
		else
			m_count = m_count - 8'd1;
		m_reload = 1'b0;
		if (m_count == '0 && m_irq_en)
			m_irq = 1'b1;
	endfunction

	function automatic mmc3_pkg::prg_bank_t expect_prg_bank(input logic [1:0] window);
		case (window)
			2'b00:   return m_mode ? mmc3_pkg::PRG_SECOND_LAST_BANK : m_r[6][5:0];
			2'b01:   return m_r[7][5:0];
			2'b10:   return m_mode ? m_r[6][5:0] : mmc3_pkg::PRG_SECOND_LAST_BANK;
			default: return mmc3_pkg::PRG_LAST_BANK;
		endcase
	endfunction

	// One CPU write cycle that lands on the closing edge
	task automatic cpu_write(input mmc3_pkg::cpu_addr_t addr, input mmc3_pkg::data_t data,
		input logic strobe);
		@(posedge clk);
		ce        <= strobe;
		prg_write <= 1'b1;
		prg_ain   <= addr;
		prg_din   <= data;
		@(posedge clk);
		ce        <= 1'b1;
		prg_write <= 1'b0;
		if (strobe)
			model_write(addr, data);
	endtask

	task automatic prg_access(input mmc3_pkg::cpu_addr_t addr, input logic wr);
		logic                ram_ok;
		logic                rom_ok;
		mmc3_pkg::mem_addr_t exp_addr;
		@(posedge clk);
		prg_ain   <= addr;
		prg_write <= wr;
		@(negedge clk);
		ram_ok = (addr[15:13] == 3'b011) && m_ram_en && !(wr && m_ram_prot);
		rom_ok = addr[15] && !wr;
		if (ram_ok)
			exp_addr = {mmc3_pkg::PRG_RAM_PREFIX, addr[12:0]};
		else
			exp_addr = {mmc3_pkg::PRG_ROM_PREFIX, expect_prg_bank(addr[14:13]), addr[12:0]};
		check_bit("prg_allow", ram_ok || rom_ok, prg_allow);
		if (ram_ok || rom_ok)
			check_addr("prg_aout", exp_addr, prg_aout);
	endtask

	task automatic chr_access(input mmc3_pkg::ppu_addr_t addr, input logic ram_flag);
		mmc3_pkg::chr_bank_t bank;
		@(posedge clk);
		chr_ain <= addr;
		chr_ram <= ram_flag;
		@(negedge clk);
		if (!(addr[12] ^ m_inv))	// 2 KB half
			bank = addr[11] ? {m_r[1][7:1], addr[10]} : {m_r[0][7:1], addr[10]};
		else
			bank = m_r[{1'b0, addr[11:10]} + 3'd2];
		check_addr("chr_aout", {mmc3_pkg::CHR_ROM_PREFIX, bank, addr[9:0]}, chr_aout);
		check_bit("chr_allow", ram_flag, chr_allow);
		check_bit("vram_a10", m_mirror ? addr[11] : addr[10], vram_a10);
		check_bit("vram_ce", addr[13], vram_ce);
	endtask

	// A12 high for two cycles and then a long low gap
	task automatic a12_pulse();
		@(posedge clk);
		chr_ain <= 14'h1000;
		@(posedge clk);
		model_a12_tick();
		@(negedge clk);
		check_bit("irq", m_irq, irq);
		@(posedge clk);
		chr_ain <= 14'h0000;
		repeat (A12_GAP) @(posedge clk);
	endtask

	initial begin
		logic [31:0]          r;
		mmc3_pkg::data_t      d;
		mmc3_pkg::bank_sel_t  idx;
		mmc3_pkg::irq_count_t n;
		mmc3_pkg::irq_count_t first;
		lfsr      = 32'h6c17;
		ce        = 1'b1;
		prg_write = 1'b0;
		prg_ain   = '0;
		prg_din   = '0;
		chr_ain   = '0;
		chr_ram   = 1'b0;
		model_reset();
		@(posedge rst_n);

		test_name = "reset";
		prg_access(16'h8000, 1'b0);	// Bank 0
		prg_access(16'hE000, 1'b0);	// Last bank
		check_bit("irq", 1'b0, irq);

		test_name = "prg_rom";
		repeat (PRG_ROUNDS) begin
			r = rand_bits(3);
			d = {r[2:1], 3'b000, 2'b11, r[0]};	// R6 or R7 with a random mode
			r = rand_bits(1);
			cpu_write(pick_reg_addr(2'b00, 1'b0), d, r[0]);
			r = rand_bits(9);
			cpu_write(pick_reg_addr(2'b00, 1'b1), r[7:0], r[8]);
			repeat (ACCESSES) begin
				r = rand_bits(15);
				prg_access({1'b1, r[14:0]}, 1'b0);
			end
		end

		test_name = "chr";
		repeat (CHR_ROUNDS) begin
			r = rand_bits(8);
			d = r[7:0];
			idx = d[2:0];
			if (idx > 3'd5)
				idx = idx - 3'd6;	// Keep to R0-R5
			d[2:0] = idx;
			cpu_write(pick_reg_addr(2'b00, 1'b0), d, 1'b1);
			r = rand_bits(8);
			cpu_write(pick_reg_addr(2'b00, 1'b1), r[7:0], 1'b1);
			repeat (ACCESSES) begin
				r = rand_bits(15);
				chr_access(r[13:0], r[14]);
			end
		end

		test_name = "prg_ram";
		repeat (RAM_ROUNDS) begin
			r = rand_bits(8);
			cpu_write(pick_reg_addr(2'b01, 1'b1), r[7:0], 1'b1);
			repeat (ACCESSES) begin
				r = rand_bits(14);
				prg_access({3'b011, r[12:0]}, r[13]);
			end
		end
		@(posedge clk);
		prg_write <= 1'b0;

		test_name = "mirroring";
		repeat (MIRROR_ROUNDS) begin
			r = rand_bits(8);
			cpu_write(pick_reg_addr(2'b01, 1'b0), r[7:0], 1'b1);
			repeat (ACCESSES) begin
				r = rand_bits(15);
				chr_access(r[13:0], r[14]);
			end
		end

		test_name = "irq";
		@(posedge clk);
		chr_ain <= '0;
		repeat (A12_GAP) @(posedge clk);	// Let the filter settle
		r = rand_bits(3);
		n = {5'b00000, r[2:0]} + 8'd1;
		cpu_write(16'hC000, n, 1'b1);
		cpu_write(16'hC001, 8'h00, 1'b1);
		cpu_write(16'hE001, 8'h00, 1'b1);
		first = '0;
		for (int k = 1; k <= int'(n) + 1; k++) begin
			a12_pulse();
			if (irq && first == '0)
				first = 8'(k);
		end
		check_count("first_edge", n + 8'd1, first);
		cpu_write(16'hE000, 8'h00, 1'b1);
		@(negedge clk);
		check_bit("irq_ack", 1'b0, irq);

		// Latch of zero fires on every edge
		cpu_write(16'hC000, 8'h00, 1'b1);
		cpu_write(16'hC001, 8'h00, 1'b1);
		cpu_write(16'hE001, 8'h00, 1'b1);
		repeat (3) begin
			a12_pulse();
			check_bit("zero_latch", 1'b1, irq);
			cpu_write(16'hE000, 8'h00, 1'b1);
			cpu_write(16'hE001, 8'h00, 1'b1);
		end

		$display("Done: no errors");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		stop_with_failure();
	end

endmodule

`default_nettype wire
